//--- source/fm_defs.svh
/*
 * Sizes, data width and register address map of the FM register block
 */
`ifndef FM_DEFS_SVH
`define FM_DEFS_SVH

// Time-division frame
`define FM_SLOTS 32
`define FM_CHANNELS 8
`define FM_OPS 4

// CPU bus byte width
`define FM_DATA_W 8

// Register map
`define FM_ADDR_KEYON 8'h08
`define FM_ADDR_CH_BASE 8'h20 // Groups at 0x20, 0x28, 0x30, 0x38
`define FM_ADDR_OP_BASE 8'h40 // Groups every 0x20 up to 0xE0

`endif

//--- source/fm_reg_pkg.sv
/*
 * Register-side types: field select, decoded data byte, operator and channel records
 */
package fm_reg_pkg;

	typedef enum logic [3:0] {
		fld_none, fld_keyon,
		fld_rl_fb_con, fld_kc, fld_kf, fld_pms_ams,
		fld_dt1_mul, fld_tl, fld_ks_ar, fld_amsen_d1r, fld_dt2_d2r, fld_d1l_rr
	} fm_field_e;

	typedef struct packed {
		logic [1:0] rl;
		logic [2:0] fb;
		logic [2:0] con;
	} fm_rl_fb_con_t;

	typedef struct packed {
		logic       pad;
		logic [2:0] dt1;
		logic [3:0] mul;
	} fm_dt1_mul_t;

	typedef struct packed {
		logic [1:0] ks;
		logic       pad;
		logic [4:0] ar;
	} fm_ks_ar_t;

	typedef struct packed {
		logic [3:0] d1l;
		logic [3:0] rr;
	} fm_d1l_rr_t;

	// Mask bit n keys operator position n
	typedef struct packed {
		logic       pad;
		logic [3:0] mask;
		logic [2:0] ch;
	} fm_keyon_t;

	typedef union packed {
		logic [7:0]    raw;
		fm_rl_fb_con_t rl_fb_con;
		fm_dt1_mul_t   dt1_mul;
		fm_ks_ar_t     ks_ar;
		fm_d1l_rr_t    d1l_rr;
		fm_keyon_t     keyon;
	} fm_data_u;

	typedef struct packed {
		logic [2:0] dt1;
		logic [3:0] mul;
		logic [6:0] tl;
		logic [1:0] ks;
		logic [4:0] ar;
		logic       amsen;
		logic [4:0] d1r;
		logic [1:0] dt2;
		logic [4:0] d2r;
		logic [3:0] d1l;
		logic [3:0] rr;
	} fm_op_rec_t; // 42 bits

	typedef struct packed {
		logic [1:0] rl;
		logic [2:0] fb;
		logic [2:0] con;
		logic [6:0] kc;
		logic [5:0] kf;
		logic [2:0] pms;
		logic [1:0] ams;
	} fm_ch_rec_t; // 26 bits

endpackage

//--- source/fm_slot_pkg.sv
/*
 * Time-division types: slot, operator position, channel and algorithm flags
 */
package fm_slot_pkg;

	typedef logic [2:0] fm_ch_t;

	// Order in which operators of a channel are visited
	typedef enum logic [1:0] {
		op_m1,
		op_m2,
		op_c1,
		op_c2
	} fm_opsel_t;

	typedef struct packed {
		fm_opsel_t op;
		fm_ch_t    ch;
	} fm_slot_t;

	// Modulation sources for the operator being computed
	typedef struct packed {
		logic use_prevprev1;
		logic use_internal_x;
		logic use_internal_y;
		logic use_prev2;
		logic use_prev1;
	} fm_alg_flags_t;

endpackage

//--- source/fm_upd_if.sv
/*
 * Update command channel from the bus decoder to the register engine
 */
`timescale 1ns/1ps

interface fm_upd_if
	import fm_reg_pkg::*, fm_slot_pkg::*;
();
	fm_data_u  data;
	fm_field_e field;
	fm_slot_t  target;
	logic      start; // One cycle, payload stable
	logic      busy;  // High from the cycle after start until commit

	modport decode (
		output data, field, target, start,
		input  busy
	);

	modport engine (
		input  data, field, target, start,
		output busy
	);
endinterface

//--- source/fm_bus_decode.sv
/*
 * CPU req/ack slave, address decode into field-update commands
 */
`timescale 1ns/1ps
`include "fm_defs.svh"

module fm_bus_decode
	import fm_reg_pkg::*, fm_slot_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  req,
	input  logic [`FM_DATA_W-1:0] addr,
	input  logic [`FM_DATA_W-1:0] wdata,
	output logic                  ack,
	fm_upd_if.decode              upd
);
	typedef enum logic [1:0] {
		st_idle,
		st_issue,
		st_wait_busy,
		st_ack_high
	} state_t;

	state_t    state;
	fm_field_e fld;
	fm_data_u  wd;
	fm_slot_t  tgt;

	assign wd = wdata;

	always_comb begin
		fld = fld_none;
		if (addr == `FM_ADDR_KEYON) begin
			fld = fld_keyon;
		end else if ((addr & 8'he0) == `FM_ADDR_CH_BASE) begin
			case (addr[4:3])
				2'd0: fld = fld_rl_fb_con;
				2'd1: fld = fld_kc;
				2'd2: fld = fld_kf;
				default: fld = fld_pms_ams;
			endcase
		end else if (addr >= `FM_ADDR_OP_BASE) begin
			case (addr[7:5])
				3'd2: fld = fld_dt1_mul;
				3'd3: fld = fld_tl;
				3'd4: fld = fld_ks_ar;
				3'd5: fld = fld_amsen_d1r;
				3'd6: fld = fld_dt2_d2r;
				3'd7: fld = fld_d1l_rr;
				default: fld = fld_none;
			endcase
		end
	end

	// Key-on names its channel in the data byte
	always_comb begin
		if (fld == fld_keyon) begin
			tgt = '{op: op_m1, ch: wd.keyon.ch};
		end else begin
			tgt = '{op: fm_opsel_t'(addr[4:3]), ch: addr[2:0]};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= st_idle;
			ack       <= 1'b0;
			upd.start <= 1'b0;
		end else begin
			upd.start <= 1'b0;
			case (state)
				st_idle: begin
					if (req && fld == fld_none) begin // Unmapped, ack straight away
						ack   <= 1'b1;
						state <= st_ack_high;
					end else if (req && !upd.busy) begin
						upd.start <= 1'b1;
						state     <= st_issue;
					end
				end
				st_issue: state <= st_wait_busy; // Engine raises busy now
				st_wait_busy: begin
					if (!upd.busy) begin
						ack   <= 1'b1;
						state <= st_ack_high;
					end
				end
				default: begin
					if (!req) begin
						ack   <= 1'b0;
						state <= st_idle;
					end
				end
			endcase
		end
	end

	// Command payload, frozen once the FSM leaves idle
	always_ff @(posedge clk) begin
		if (state == st_idle && req) begin
			upd.data   <= wd;
			upd.field  <= fld;
			upd.target <= tgt;
		end
	end

endmodule

//--- source/fm_reg.sv
/*
 * Slot counter, operator and channel parameter memories,
 * read-modify-write commit of field updates and reset clear sweep
 */
`timescale 1ns/1ps
`include "fm_defs.svh"

module fm_reg
	import fm_reg_pkg::*, fm_slot_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	fm_upd_if.engine   upd,
	output fm_slot_t   slot,
	output fm_op_rec_t op_rec,
	output fm_ch_rec_t ch_rec,
	output logic [2:0] con,
	output logic       kon_wr,
	output logic [3:0] kon_mask,
	output fm_ch_t     kon_ch
);
	logic [4:0] cnt;
	fm_slot_t   cur;
	logic       sweep;
	logic       pend;

	fm_op_rec_t op_mem [`FM_SLOTS];
	fm_ch_rec_t ch_mem [`FM_CHANNELS];

	fm_op_rec_t op_old;
	fm_op_rec_t op_new;
	fm_ch_rec_t ch_old;
	fm_ch_rec_t ch_new;
	fm_data_u   d;

	logic is_op, is_ch, is_kon;
	logic op_commit, ch_commit, kon_commit, commit;

	assign cur    = cnt;
	assign d      = upd.data;
	assign op_old = op_mem[cnt];
	assign ch_old = ch_mem[cur.ch];

	assign is_kon = upd.field == fld_keyon;
	assign is_ch  = upd.field inside {fld_rl_fb_con, fld_kc, fld_kf, fld_pms_ams};
	assign is_op  = upd.field inside {fld_dt1_mul, fld_tl, fld_ks_ar,
		fld_amsen_d1r, fld_dt2_d2r, fld_d1l_rr};

	// Operator writes wait for the exact slot, the rest for the channel
	assign op_commit  = pend && is_op && upd.target == cur;
	assign ch_commit  = pend && is_ch && upd.target.ch == cur.ch;
	assign kon_commit = pend && is_kon && upd.target.ch == cur.ch;
	assign commit     = op_commit || ch_commit || kon_commit;

	assign upd.busy = pend | sweep;
	assign con      = ch_rec.con;

	always_comb begin
		op_new = op_old; // Untouched fields keep their value
		case (upd.field)
			fld_dt1_mul: begin
				op_new.dt1 = d.dt1_mul.dt1;
				op_new.mul = d.dt1_mul.mul;
			end
			fld_tl: op_new.tl = d.raw[6:0];
			fld_ks_ar: begin
				op_new.ks = d.ks_ar.ks;
				op_new.ar = d.ks_ar.ar;
			end
			fld_amsen_d1r: begin
				op_new.amsen = d.raw[7];
				op_new.d1r   = d.raw[4:0];
			end
			fld_dt2_d2r: begin
				op_new.dt2 = d.raw[7:6];
				op_new.d2r = d.raw[4:0];
			end
			fld_d1l_rr: begin
				op_new.d1l = d.d1l_rr.d1l;
				op_new.rr  = d.d1l_rr.rr;
			end
			default: ;
		endcase
	end

	always_comb begin
		ch_new = ch_old;
		case (upd.field)
			fld_rl_fb_con: begin
				ch_new.rl  = d.rl_fb_con.rl;
				ch_new.fb  = d.rl_fb_con.fb;
				ch_new.con = d.rl_fb_con.con;
			end
			fld_kc: ch_new.kc = d.raw[6:0];
			fld_kf: ch_new.kf = d.raw[7:2];
			fld_pms_ams: begin
				ch_new.pms = d.raw[6:4];
				ch_new.ams = d.raw[1:0];
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt    <= '0;
			slot   <= '0;
			sweep  <= 1'b1;
			pend   <= 1'b0;
			kon_wr <= 1'b0;
		end else begin
			cnt    <= cnt + 5'd1;
			slot   <= cur;
			kon_wr <= kon_commit; // Lands with busy falling
			if (sweep && cnt == 5'(`FM_SLOTS - 1))
				sweep <= 1'b0;
			if (upd.start)
				pend <= 1'b1;
			else if (commit)
				pend <= 1'b0;
		end
	end

	// Output registers read the value held before a same-cycle commit
	always_ff @(posedge clk) begin
		if (sweep) begin
			op_mem[cnt]    <= '0;
			ch_mem[cur.ch] <= '0;
		end else begin
			if (op_commit)
				op_mem[cnt] <= op_new;
			if (ch_commit)
				ch_mem[cur.ch] <= ch_new;
		end
		op_rec   <= sweep ? '0 : op_old;
		ch_rec   <= sweep ? '0 : ch_old;
		kon_mask <= d.keyon.mask;
		kon_ch   <= d.keyon.ch;
	end

endmodule

//--- source/fm_kon.sv
/*
 * Key-on bit per slot, written a channel at a time
 */
`timescale 1ns/1ps
`include "fm_defs.svh"

module fm_kon
	import fm_slot_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  fm_slot_t   slot,
	input  logic       kon_wr,
	input  logic [3:0] kon_mask,
	input  fm_ch_t     kon_ch,
	output logic       keyon
);
	logic [`FM_SLOTS-1:0] kon_bits; // Indexed like the slot, op above channel

	always_ff @(posedge clk) begin
		if (rst) begin
			kon_bits <= '0;
		end else if (kon_wr) begin
			// All four operators of the channel, set or cleared together
			for (int i = 0; i < `FM_OPS; i++) begin
				kon_bits[i * `FM_CHANNELS + kon_ch] <= kon_mask[i];
			end
		end
	end

	assign keyon = kon_bits[slot]; // Same slot as the other outputs

endmodule

//--- source/fm_alg.sv
/*
 * OPM connection decoder: modulation sources per operator position
 */
`timescale 1ns/1ps

module fm_alg
	import fm_slot_pkg::*;
(
	input  logic [2:0]    con,
	input  fm_opsel_t     opsel,
	output fm_alg_flags_t flags
);
	logic [7:0] hot; // One-hot algorithm number

	assign hot = 8'd1 << con;

	always_comb begin
		flags = '0;
		case (opsel)
			op_m1: begin
				// Self feedback from its last two outputs
				flags.use_prevprev1 = 1'b1;
				flags.use_prev1     = 1'b1;
			end
			op_m2: begin
				flags.use_prevprev1 = hot[5];       // M1 drives all three carriers
				flags.use_prev2     = |hot[2:0];
				flags.use_prev1     = hot[1];
			end
			op_c1: flags.use_prev1 = |{hot[6:3], hot[0]};
			op_c2: begin
				flags.use_internal_x = hot[2];
				flags.use_internal_y = |{hot[4:3], hot[1:0]};
				flags.use_prev2      = hot[3];
				flags.use_prev1      = hot[5] | hot[2];
			end
			default: ;
		endcase
	end

endmodule

//--- source/fm_regs_top.sv
/*
 * Register block top: bus decoder, register engine, key-on store, algorithm decoder
 */
`timescale 1ns/1ps
`include "fm_defs.svh"

module fm_regs_top
	import fm_reg_pkg::*, fm_slot_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  req,
	input  logic [`FM_DATA_W-1:0] addr,
	input  logic [`FM_DATA_W-1:0] wdata,
	output logic                  ack,
	output logic [4:0]            slot,
	output logic [2:0]            dt1,
	output logic [3:0]            mul,
	output logic [6:0]            tl,
	output logic [1:0]            ks,
	output logic [4:0]            ar,
	output logic                  amsen,
	output logic [4:0]            d1r,
	output logic [1:0]            dt2,
	output logic [4:0]            d2r,
	output logic [3:0]            d1l,
	output logic [3:0]            rr,
	output logic [1:0]            rl,
	output logic [2:0]            fb,
	output logic [2:0]            con,
	output logic [6:0]            kc,
	output logic [5:0]            kf,
	output logic [2:0]            pms,
	output logic [1:0]            ams,
	output logic                  keyon,
	output logic                  use_prevprev1,
	output logic                  use_internal_x,
	output logic                  use_internal_y,
	output logic                  use_prev2,
	output logic                  use_prev1
);
	fm_upd_if upd ();

	fm_slot_t      slot_w;
	fm_op_rec_t    op_rec;
	fm_ch_rec_t    ch_rec;
	logic          kon_wr;
	logic [3:0]    kon_mask;
	fm_ch_t        kon_ch;
	fm_alg_flags_t flags;

	fm_bus_decode u_decode (
		.clk   (clk),
		.rst   (rst),
		.req   (req),
		.addr  (addr),
		.wdata (wdata),
		.ack   (ack),
		.upd   (upd)
	);

	fm_reg u_reg (
		.clk      (clk),
		.rst      (rst),
		.upd      (upd),
		.slot     (slot_w),
		.op_rec   (op_rec),
		.ch_rec   (ch_rec),
		.con      (con),
		.kon_wr   (kon_wr),
		.kon_mask (kon_mask),
		.kon_ch   (kon_ch)
	);

	fm_kon u_kon (
		.clk      (clk),
		.rst      (rst),
		.slot     (slot_w),
		.kon_wr   (kon_wr),
		.kon_mask (kon_mask),
		.kon_ch   (kon_ch),
		.keyon    (keyon)
	);

	fm_alg u_alg (
		.con   (con),
		.opsel (slot_w.op),
		.flags (flags)
	);

	assign slot  = slot_w;

	assign dt1   = op_rec.dt1;
	assign mul   = op_rec.mul;
	assign tl    = op_rec.tl;
	assign ks    = op_rec.ks;
	assign ar    = op_rec.ar;
	assign amsen = op_rec.amsen;
	assign d1r   = op_rec.d1r;
	assign dt2   = op_rec.dt2;
	assign d2r   = op_rec.d2r;
	assign d1l   = op_rec.d1l;
	assign rr    = op_rec.rr;

	assign rl    = ch_rec.rl; // CON comes out of the engine directly
	assign fb    = ch_rec.fb;
	assign kc    = ch_rec.kc;
	assign kf    = ch_rec.kf;
	assign pms   = ch_rec.pms;
	assign ams   = ch_rec.ams;

	assign use_prevprev1  = flags.use_prevprev1;
	assign use_internal_x = flags.use_internal_x;
	assign use_internal_y = flags.use_internal_y;
	assign use_prev2      = flags.use_prev2;
	assign use_prev1      = flags.use_prev1;

endmodule

//--- tests/fm_regs_sva.sv
/*
 * Handshake and busy rules of the bus decoder
 */
`timescale 1ns/1ps

module fm_regs_sva (
	input logic clk,
	input logic rst,
	input logic req,
	input logic ack,
	input logic start,
	input logic busy
);
	int fail_count = 0; // Read by the testbench at the end

	// Decoder set ack on an edge where it saw req
	ack_needs_req: assert property (@(posedge clk) disable iff (rst)
		$rose(ack) |-> $past(req))
	else begin
		$error("ack rose while req was low");
		fail_count++;
	end

	ack_drop_after_req: assert property (@(posedge clk) disable iff (rst)
		$fell(ack) |-> !$past(req))
	else begin
		$error("ack fell while req was still high");
		fail_count++;
	end

	start_not_busy: assert property (@(posedge clk) disable iff (rst)
		$rose(start) |-> !$past(busy))
	else begin
		$error("start issued while the engine was busy");
		fail_count++;
	end

endmodule

//--- tests/fm_regs_checker.sv
/*
 * Register model of the FM block, compared against every played slot
 */
`timescale 1ns/1ps
`include "fm_defs.svh"

module fm_regs_checker (
	input  logic       clk,
	input  logic       rst,
	input  logic [7:0] addr,
	input  logic [7:0] wdata,
	input  logic       ack,
	input  logic [4:0] slot,
	input  logic [2:0] dt1,
	input  logic [3:0] mul,
	input  logic [6:0] tl,
	input  logic [1:0] ks,
	input  logic [4:0] ar,
	input  logic       amsen,
	input  logic [4:0] d1r,
	input  logic [1:0] dt2,
	input  logic [4:0] d2r,
	input  logic [3:0] d1l,
	input  logic [3:0] rr,
	input  logic [1:0] rl,
	input  logic [2:0] fb,
	input  logic [2:0] con,
	input  logic [6:0] kc,
	input  logic [5:0] kf,
	input  logic [2:0] pms,
	input  logic [1:0] ams,
	input  logic       keyon,
	input  logic       use_prevprev1,
	input  logic       use_internal_x,
	input  logic       use_internal_y,
	input  logic       use_prev2,
	input  logic       use_prev1,
	output int         mismatch_count
);
	// {dt1, mul, tl, ks, ar, amsen, d1r, dt2, d2r, d1l, rr}
	logic [41:0] op_m [`FM_SLOTS];
	// {rl, fb, con, kc, kf, pms, ams}
	logic [25:0] ch_m [`FM_CHANNELS];
	logic [`FM_SLOTS-1:0] kon_m;
	logic [4:0] exp_slot;
	logic       run;
	logic       ack_q;
	logic [5:0] ent;

	// Connection table, {valid, prevprev1, internal_x, internal_y, prev2, prev1}
	function automatic logic [5:0] conn_entry(input logic [2:0] c, input logic [1:0] op);
		if (op == 2'd0)
			return {1'b1, 5'b10001}; // M1 feeds back on itself in every algorithm
		case ({c, op})
			{3'd0, 2'd1}: return {1'b1, 5'b00010}; // M2 from C1
			{3'd0, 2'd2}: return {1'b1, 5'b00001}; // C1 from M1
			{3'd0, 2'd3}: return {1'b1, 5'b00100}; // C2 from M2
			{3'd7, 2'd1}, {3'd7, 2'd2}, {3'd7, 2'd3}: return {1'b1, 5'b00000};
			default: return 6'd0;
		endcase
	endfunction

	task automatic apply_write(input logic [7:0] a, input logic [7:0] d);
		logic [4:0] s;
		logic [2:0] c;
		s = a[4:0];
		c = a[2:0];
		if (a == `FM_ADDR_KEYON) begin
			for (int i = 0; i < `FM_OPS; i++)
				kon_m[i * `FM_CHANNELS + d[2:0]] = d[3 + i]; // Mask bit per position
		end else if (a[7:5] == 3'd1) begin
			case (a[4:3])
				2'd0: ch_m[c][25:18] = d;
				2'd1: ch_m[c][17:11] = d[6:0];
				2'd2: ch_m[c][10:5] = d[7:2];
				default: begin
					ch_m[c][4:2] = d[6:4];
					ch_m[c][1:0] = d[1:0];
				end
			endcase
		end else if (a[7:5] >= 3'd2) begin
			case (a[7:5])
				3'd2: op_m[s][41:35] = d[6:0]; // DT1 and MUL
				3'd3: op_m[s][34:28] = d[6:0];
				3'd4: begin
					op_m[s][27:26] = d[7:6];
					op_m[s][25:21] = d[4:0];
				end
				3'd5: begin
					op_m[s][20]    = d[7];
					op_m[s][19:15] = d[4:0];
				end
				3'd6: begin
					op_m[s][14:13] = d[7:6];
					op_m[s][12:8]  = d[4:0];
				end
				default: op_m[s][7:0] = d; // D1L and RR
			endcase
		end
	endtask

	task automatic check_value(input string what, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			mismatch_count++;
			$display("mismatch at %0t: %s for slot %0d, got %h expected %h",
				$time, what, exp_slot, got, exp);
		end
	endtask

	always @(posedge clk) begin
		run <= !rst;
	end

	// Outputs settle after the rising edge
	always @(negedge clk) begin
		if (run !== 1'b1) begin
			for (int i = 0; i < `FM_SLOTS; i++)
				op_m[i] = '0;
			for (int i = 0; i < `FM_CHANNELS; i++)
				ch_m[i] = '0;
			kon_m          = '0;
			exp_slot       = '0;
			ack_q          = 1'b0;
			mismatch_count = 0;
		end else begin
			if (ack && !ack_q)
				apply_write(addr, wdata); // Commit is done once ack rises
			ack_q = ack;
			check_value("slot", slot, exp_slot);
			check_value("operator fields", {dt1, mul, tl, ks, ar, amsen, d1r, dt2, d2r, d1l, rr},
				op_m[exp_slot]);
			check_value("channel fields", {rl, fb, con, kc, kf, pms, ams},
				ch_m[exp_slot[2:0]]);
			check_value("keyon", keyon, kon_m[exp_slot]);
			ent = conn_entry(ch_m[exp_slot[2:0]][20:18], exp_slot[4:3]);
			if (ent[5]) begin
				check_value("algorithm flags", {use_prevprev1, use_internal_x,
					use_internal_y, use_prev2, use_prev1}, ent[4:0]);
			end
			exp_slot = exp_slot + 5'd1;
		end
	end

endmodule

//--- tests/fm_regs_tb.sv
/*
 * Testbench for the FM register block: clock, reset, CPU handshake and write table
 */
`timescale 1ns/1ps

module fm_regs_tb;
	localparam int n_rows = 23;

	logic       clk;
	logic       rst;
	logic       req;
	logic [7:0] addr;
	logic [7:0] wdata;
	logic       ack;
	logic [4:0] slot;
	logic [2:0] dt1;
	logic [3:0] mul;
	logic [6:0] tl;
	logic [1:0] ks;
	logic [4:0] ar;
	logic       amsen;
	logic [4:0] d1r;
	logic [1:0] dt2;
	logic [4:0] d2r;
	logic [3:0] d1l;
	logic [3:0] rr;
	logic [1:0] rl;
	logic [2:0] fb;
	logic [2:0] con;
	logic [6:0] kc;
	logic [5:0] kf;
	logic [2:0] pms;
	logic [1:0] ams;
	logic       keyon;
	logic       use_prevprev1;
	logic       use_internal_x;
	logic       use_internal_y;
	logic       use_prev2;
	logic       use_prev1;
	int         mismatch_count;
	int         timeout_count;
	logic       stop;

	// Write table: address, data, most cycles until ack, random data
	logic [7:0] tbl_addr [n_rows];
	logic [7:0] tbl_data [n_rows];
	int         tbl_lat  [n_rows];
	bit         tbl_rnd  [n_rows];

	fm_regs_top u_fm_regs_top (.*);

	fm_regs_checker u_checker (.*);

	bind fm_bus_decode fm_regs_sva u_sva (
		.clk   (clk),
		.rst   (rst),
		.req   (req),
		.ack   (ack),
		.start (upd.start),
		.busy  (upd.busy)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	task automatic set_row(input int i, input logic [7:0] a, input logic [7:0] d,
		input int lat, input bit rnd);
		tbl_addr[i] = a;
		tbl_data[i] = d;
		tbl_lat[i]  = lat;
		tbl_rnd[i]  = rnd;
	endtask

	task automatic fill_table();
		// Operator groups at slot 5, two at slot 26 (bound 36 cycles)
		set_row(0, 8'h45, 8'h00, 36, 1);
		set_row(1, 8'h65, 8'h00, 36, 1);
		set_row(2, 8'h85, 8'h00, 36, 1);
		set_row(3, 8'ha5, 8'h00, 36, 1);
		set_row(4, 8'hc5, 8'h00, 36, 1);
		set_row(5, 8'he5, 8'h00, 36, 1);
		set_row(6, 8'h5a, 8'h00, 36, 1);
		set_row(7, 8'hda, 8'h00, 36, 1);
		// Channel groups, CON 0 then 7 on channel 3
		set_row(8, 8'h23, 8'hc0, 12, 0);
		set_row(9, 8'h2b, 8'h00, 12, 1);
		set_row(10, 8'h33, 8'h00, 12, 1);
		set_row(11, 8'h3b, 8'h00, 12, 1);
		set_row(12, 8'h23, 8'h7f, 12, 0);
		set_row(13, 8'h26, 8'h80, 12, 0);
		// Key-on: mask in bits 6..3, channel in 2..0
		set_row(14, 8'h08, 8'h5b, 12, 0);
		set_row(15, 8'h08, 8'h13, 12, 0);
		set_row(16, 8'h08, 8'h7e, 12, 0);
		set_row(17, 8'h08, 8'h06, 12, 0);
		// Unmapped, acked on the next cycle
		set_row(18, 8'h00, 8'h00, 2, 1);
		set_row(19, 8'h15, 8'h00, 2, 1);
		set_row(20, 8'h1f, 8'h00, 2, 1);
		set_row(21, 8'he5, 8'h00, 36, 0);
		set_row(22, 8'h27, 8'h00, 12, 1);
	endtask

	// Four-phase write, called on a falling edge
	task automatic write_row(input int i);
		int n;
		addr  = tbl_addr[i];
		wdata = tbl_rnd[i] ? 8'($urandom) : tbl_data[i];
		req   = 1'b1;
		n     = 0;
		while (ack !== 1'b1 && n < tbl_lat[i]) begin
			@(negedge clk);
			n++;
		end
		req = 1'b0;
		if (ack !== 1'b1) begin
			$display("Timeout: no ack within %0d cycles for the write to address %h",
				tbl_lat[i], tbl_addr[i]);
			timeout_count++;
			stop = 1'b1;
		end else begin
			n = 0;
			while (ack !== 1'b0 && n < 4) begin
				@(negedge clk);
				n++;
			end
			if (ack !== 1'b0) begin
				$display("Timeout: ack stayed high after req was dropped, address %h",
					tbl_addr[i]);
				timeout_count++;
				stop = 1'b1;
			end
		end
	endtask

	task automatic finish_run();
		int sva_fails;
		sva_fails = u_fm_regs_top.u_decode.u_sva.fail_count;
		$display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
			mismatch_count, timeout_count, sva_fails);
		if (mismatch_count == 0 && timeout_count == 0 && sva_fails == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	endtask

	initial begin
		void'($urandom(32'hd5c2));
		rst           = 1'b1;
		req           = 1'b0;
		addr          = 8'h00;
		wdata         = 8'h00;
		stop          = 1'b0;
		timeout_count = 0;
		fill_table();
		repeat (2) @(negedge clk);
		rst = 1'b0;
		repeat (70) @(negedge clk); // Clear sweep, then a full frame of zeros
		for (int i = 0; i < n_rows && !stop; i++) begin
			write_row(i);
			repeat (34) @(negedge clk); // Let every slot play the new value
		end
		finish_run();
	end

endmodule

//--- verilog.f
+incdir+source
source/fm_reg_pkg.sv
source/fm_slot_pkg.sv
source/fm_upd_if.sv
source/fm_bus_decode.sv
source/fm_reg.sv
source/fm_kon.sv
source/fm_alg.sv
source/fm_regs_top.sv
tests/fm_regs_sva.sv
tests/fm_regs_checker.sv
tests/fm_regs_tb.sv
